// File: logic/msdapPkg.sv
package msdapPkg;

    // serial link
    localparam int WordBits = 16;

    // table and memory sizes
    localparam int NumRj = 16;
    localparam int NumCoeff = 512;
    localparam int NumTaps = 256;

    localparam int RjAddrBits = $clog2(NumRj);
    localparam int CoeffAddrBits = $clog2(NumCoeff);
    localparam int TapAddrBits = $clog2(NumTaps);

    // datapath widths
    localparam int RjBits = 8;
    localparam int AccBits = 24;
    localparam int ResultBits = 40;

    // audio sample, also the raw word off the serial link
    typedef logic signed [WordBits-1:0] sampleT;

    // sign in the top bit, tap index below it
    typedef logic [TapAddrBits:0] coeffT;

    typedef logic [RjBits-1:0] rjT; // coefficients in one group

    typedef logic signed [AccBits-1:0] accT;
    typedef logic signed [ResultBits-1:0] resultT;

    typedef enum logic [1:0] {
        loadRj,
        loadCoeff,
        run
    } phaseT;

endpackage

// File: logic/loadBus.sv
interface loadBus import msdapPkg::*; ();

    sampleT wordL;
    sampleT wordR;

    // write strobes, one cycle each
    logic rjWe;
    logic coeffWe;
    logic sampleWe; // also starts both engines

    logic [CoeffAddrBits-1:0] addr; // rj index sits in the low bits

    modport ctrl (
        output wordL,
        output wordR,
        output rjWe,
        output coeffWe,
        output sampleWe,
        output addr
    );

    modport store (
        input rjWe,
        input coeffWe,
        input sampleWe,
        input addr
    );

endinterface

// File: logic/tapPort.sv
interface tapPort import msdapPkg::*; ();

    logic [RjAddrBits-1:0] rjSel;
    logic [CoeffAddrBits-1:0] coeffAddr;
    logic [TapAddrBits-1:0] tapAddr; // 0 is newest sample

    // read data, no latency
    rjT rjCount;
    coeffT coeff;
    sampleT tap;

    modport store (
        input rjSel,
        input coeffAddr,
        input tapAddr,
        output rjCount,
        output coeff,
        output tap
    );

    modport engine (
        output rjSel,
        output coeffAddr,
        output tapAddr,
        input rjCount,
        input coeff,
        input tap
    );

endinterface

// File: logic/serialIn.sv
module serialIn import msdapPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   frame,
    input  logic   inL,
    input  logic   inR,
    input  logic   accept,
    output sampleT wordL,
    output sampleT wordR,
    output logic   wordValid
);

    logic capturing;
    logic [$clog2(WordBits)-1:0] bitCount;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            capturing <= 1'b0;
            bitCount <= '0;
            wordL <= '0;
            wordR <= '0;
            wordValid <= 1'b0;
        end else begin
            wordValid <= 1'b0;
            // frame cycle already carries the msb
            if (capturing || (frame && accept)) begin
                wordL <= {wordL[WordBits-2:0], inL};
                wordR <= {wordR[WordBits-2:0], inR};
                bitCount <= bitCount + 1'b1; // wraps to 0 after the lsb
                capturing <= 1'b1;
                if (bitCount == '1) begin
                    capturing <= 1'b0;
                    wordValid <= 1'b1;
                end
            end
        end
    end

    // frames must line up with word boundaries
    assert property (@(posedge clk) disable iff (rst) capturing |-> !frame)
        else $error("frame seen in the middle of a serial word");

endmodule

// File: logic/loadControl.sv
module loadControl import msdapPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  sampleT wordL,
    input  sampleT wordR,
    input  logic   wordValid,
    input  logic   busy,
    output logic   inReady,
    loadBus.ctrl   ld
);

    phaseT phase;
    logic [CoeffAddrBits-1:0] wordCount;

    logic rjWe;
    logic coeffWe;
    logic sampleWe;

    assign rjWe = wordValid && (phase == loadRj);
    assign coeffWe = wordValid && (phase == loadCoeff);
    assign sampleWe = wordValid && (phase == run);

    assign ld.wordL = wordL;
    assign ld.wordR = wordR;
    assign ld.rjWe = rjWe;
    assign ld.coeffWe = coeffWe;
    assign ld.sampleWe = sampleWe;
    assign ld.addr = wordCount;

    // low from the sample strobe through the done cycle
    assign inReady = !(sampleWe || busy);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= loadRj;
            wordCount <= '0;
        end else if (wordValid) begin
            case (phase)
                loadRj: begin
                    if (wordCount == CoeffAddrBits'(NumRj - 1)) begin
                        phase <= loadCoeff;
                        wordCount <= '0;
                    end else begin
                        wordCount <= wordCount + 1'b1;
                    end
                end
                loadCoeff: begin
                    wordCount <= wordCount + 1'b1; // wraps to 0 on the last one
                    if (wordCount == CoeffAddrBits'(NumCoeff - 1)) begin
                        phase <= run;
                    end
                end
                default: wordCount <= '0; // samples carry no address
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst) $onehot0({rjWe, coeffWe, sampleWe}))
        else $error("more than one load strobe active");

endmodule

// File: logic/tapStore.sv
module tapStore import msdapPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  sampleT word,
    loadBus.store  ld,
    tapPort.store  tp
);

    rjT rjTable [NumRj];
    coeffT coeffMem [NumCoeff];
    sampleT hist [NumTaps];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NumRj; i++) begin
                rjTable[i] <= '0;
            end
        end else if (ld.rjWe) begin
            rjTable[ld.addr[RjAddrBits-1:0]] <= word[RjBits-1:0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NumCoeff; i++) begin
                coeffMem[i] <= '0;
            end
        end else if (ld.coeffWe) begin
            coeffMem[ld.addr] <= word[TapAddrBits:0]; // sign + index
        end
    end

    // history shifts by one per sample, newest at tap 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NumTaps; i++) begin
                hist[i] <= '0;
            end
        end else if (ld.sampleWe) begin
            hist[0] <= word;
            for (int i = 1; i < NumTaps; i++) begin
                hist[i] <= hist[i-1];
            end
        end
    end

    assign tp.rjCount = rjTable[tp.rjSel];
    assign tp.coeff = coeffMem[tp.coeffAddr];
    assign tp.tap = hist[tp.tapAddr];

endmodule

// File: logic/macEngine.sv
module macEngine import msdapPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    output logic   busy,
    output logic   done,
    output resultT result,
    tapPort.engine tp
);

    typedef enum logic [1:0] {
        sIdle,
        sWalk,
        sShift,
        sPresent
    } stateT;

    stateT state;
    logic [RjAddrBits-1:0] grp;
    logic [CoeffAddrBits-1:0] coeffAddr;
    rjT cnt; // position inside the current group
    accT acc;
    resultT work;

    accT tapExt;
    accT addend;
    accT top;
    resultT merged;
    resultT shifted;
    logic negCoeff;
    logic lastGrp;

    // shift cycle looks ahead to the next group's count
    assign tp.rjSel = (state == sShift) ? grp + 1'b1 : grp;
    assign tp.coeffAddr = coeffAddr;
    assign tp.tapAddr = tp.coeff[TapAddrBits-1:0];

    assign negCoeff = tp.coeff[TapAddrBits];
    assign tapExt = accT'(tp.tap);
    assign addend = negCoeff ? ~tapExt : tapExt; // +1 comes in as carry below

    // group sum lands on the top bits, then halve
    assign top = work[ResultBits-1 -: AccBits] + acc;
    assign merged = {top, work[ResultBits-AccBits-1:0]};
    assign shifted = merged >>> 1;

    assign lastGrp = grp == RjAddrBits'(NumRj - 1);

    assign busy = state != sIdle;
    assign done = state == sPresent;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= sIdle;
            grp <= '0;
            coeffAddr <= '0;
            cnt <= '0;
            acc <= '0;
            work <= '0;
            result <= '0;
        end else begin
            case (state)
                sIdle: begin
                    if (start) begin
                        grp <= '0;
                        coeffAddr <= '0;
                        cnt <= '0;
                        acc <= '0;
                        work <= '0;
                        state <= (tp.rjCount == '0) ? sShift : sWalk; // empty group 0
                    end
                end
                sWalk: begin
                    acc <= acc + addend + accT'(negCoeff);
                    coeffAddr <= coeffAddr + 1'b1;
                    if (cnt == tp.rjCount - 1'b1) begin
                        cnt <= '0;
                        state <= sShift;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                sShift: begin
                    work <= shifted;
                    acc <= '0;
                    grp <= grp + 1'b1;
                    if (lastGrp) begin
                        result <= shifted;
                        state <= sPresent;
                    end else if (tp.rjCount != '0) begin
                        state <= sWalk;
                    end
                    // empty next group stays here for its shift
                end
                default: state <= sIdle; // present lasts one cycle
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst) start |-> !busy)
        else $error("sample arrived while engine busy");

endmodule

// File: logic/msdapTop.sv
module msdapTop import msdapPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   frame,
    input  logic   inL,
    input  logic   inR,
    output logic   inReady,
    output logic   outReady,
    output resultT outL,
    output resultT outR
);

    sampleT wordL;
    sampleT wordR;
    logic wordValid;
    logic busyL;
    logic doneL;
    logic doneR;

    loadBus ld ();
    tapPort tpL ();
    tapPort tpR ();

    serialIn deser (
        .clk       (clk),
        .rst       (rst),
        .frame     (frame),
        .inL       (inL),
        .inR       (inR),
        .accept    (inReady),
        .wordL     (wordL),
        .wordR     (wordR),
        .wordValid (wordValid)
    );

    loadControl loader (
        .clk       (clk),
        .rst       (rst),
        .wordL     (wordL),
        .wordR     (wordR),
        .wordValid (wordValid),
        .busy      (busyL),
        .inReady   (inReady),
        .ld        (ld.ctrl)
    );

    tapStore storeL (.clk(clk), .rst(rst), .word(ld.wordL), .ld(ld.store), .tp(tpL.store));
    tapStore storeR (.clk(clk), .rst(rst), .word(ld.wordR), .ld(ld.store), .tp(tpR.store));

    macEngine engL (
        .clk(clk), .rst(rst), .start(ld.sampleWe),
        .busy(busyL), .done(doneL), .result(outL), .tp(tpL.engine)
    );

    // right channel runs in lockstep, its busy is not needed
    macEngine engR (
        .clk(clk), .rst(rst), .start(ld.sampleWe),
        .busy(), .done(doneR), .result(outR), .tp(tpR.engine)
    );

    assign outReady = doneL;

    assert property (@(posedge clk) disable iff (rst) doneL == doneR)
        else $error("left and right channels finished in different cycles");

endmodule

// File: bench/tbMsdap.sv
module tbMsdap import msdapPkg::*; ();

    localparam int LoadWords = 3 * (NumRj + NumCoeff);
    localparam int SampleWords = 30; // incl. ignored and cut-off frames
    localparam int TimeoutCycles = (17 * LoadWords + 600 * SampleWords) * 6 / 5;

    logic clk = 1'b0;
    logic rst;
    logic frame;
    logic inL;
    logic inR;
    logic inReady;
    logic outReady;
    resultT outL;
    resultT outR;

    integer seed;
    int cycles = 0;
    int checkCount = 0;
    int errorCount = 0;

    // bench copy of both channels' tables and history
    int rjModel [2][NumRj];
    coeffT coeffModel [2][NumCoeff];
    sampleT histModel [2][NumTaps];

    msdapTop UUT (
        .clk      (clk),
        .rst      (rst),
        .frame    (frame),
        .inL      (inL),
        .inR      (inR),
        .inReady  (inReady),
        .outReady (outReady),
        .outL     (outL),
        .outR     (outR)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TimeoutCycles) begin
            $display("run stopped after %0d cycles, DUT did not finish in time", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [39:0] expected,
                              input logic [39:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic finishTest(input string name, input int errBefore);
        $display("%s test finished with %0d errors", name, errorCount - errBefore);
    endtask

    task automatic applyReset();
        @(posedge clk);
        rst <= 1'b1;
        frame <= 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (int ch = 0; ch < 2; ch++) begin
            for (int i = 0; i < NumTaps; i++) begin
                histModel[ch][i] = '0;
            end
        end
    endtask

    // msb goes out with the frame bit
    task automatic sendBits(input logic [15:0] wl, input logic [15:0] wr);
        @(posedge clk);
        frame <= 1'b1;
        inL <= wl[15];
        inR <= wr[15];
        for (int b = 14; b >= 0; b--) begin
            @(posedge clk);
            frame <= 1'b0;
            inL <= wl[b];
            inR <= wr[b];
        end
    endtask

    task automatic sendWord(input logic [15:0] wl, input logic [15:0] wr);
        @(negedge clk);
        while (!inReady) @(negedge clk);
        sendBits(wl, wr);
    endtask

    task automatic loadTables(input logic [15:0] emptyMask, input logic [7:0] idxMask);
        int g;
        for (int ch = 0; ch < 2; ch++) begin
            for (int i = 0; i < NumRj; i++) begin
                rjModel[ch][i] = 0;
            end
            for (int n = 0; n < NumCoeff; n++) begin
                do g = $unsigned($random(seed)) % NumRj; while (emptyMask[g]);
                rjModel[ch][g]++;
            end
            for (int k = 0; k < NumCoeff; k++) begin
                coeffModel[ch][k] = 9'($random(seed)) & {1'b1, idxMask};
            end
        end
        for (int i = 0; i < NumRj; i++) begin
            sendWord(16'(rjModel[0][i]), 16'(rjModel[1][i]));
        end
        for (int k = 0; k < NumCoeff; k++) begin
            sendWord({7'b0, coeffModel[0][k]}, {7'b0, coeffModel[1][k]});
        end
    endtask

    task automatic pushSample(input sampleT sl, input sampleT sr);
        for (int i = NumTaps - 1; i > 0; i--) begin
            histModel[0][i] = histModel[0][i-1];
            histModel[1][i] = histModel[1][i-1];
        end
        histModel[0][0] = sl;
        histModel[1][0] = sr;
    endtask

    // group sum into the top 24 bits, then halve
    function automatic resultT modelResult(input int ch);
        resultT work;
        accT grpSum;
        accT tapVal;
        accT top;
        coeffT c;
        int k;
        work = '0;
        k = 0;
        for (int g = 0; g < NumRj; g++) begin
            grpSum = '0;
            for (int j = 0; j < rjModel[ch][g]; j++) begin
                c = coeffModel[ch][k];
                tapVal = histModel[ch][c[7:0]];
                grpSum = c[8] ? grpSum - tapVal : grpSum + tapVal;
                k++;
            end
            top = work[39:16] + grpSum;
            work = {top, work[15:0]};
            work = work >>> 1;
        end
        return work;
    endfunction

    task automatic runSample(input string name, input sampleT sl, input sampleT sr,
                             input bit junk);
        resultT expL;
        resultT expR;
        int n;
        int highCount;
        pushSample(sl, sr);
        expL = modelResult(0);
        expR = modelResult(1);
        sendWord(sl, sr);
        n = 0;
        highCount = 0;
        @(negedge clk);
        while (inReady && n < 4) begin
            n++;
            @(negedge clk);
        end
        if (inReady) begin
            errorCount++;
            $display("%s: inReady did not drop after the sample word", name);
            return;
        end
        if (junk) begin
            sendBits(16'($random(seed)), 16'($random(seed))); // should be dropped
            @(negedge clk);
        end
        n = 0;
        while (!outReady && n < 600) begin
            if (inReady) highCount++;
            n++;
            @(negedge clk);
        end
        if (!outReady) begin
            errorCount++;
            $display("%s: no outReady within 600 cycles of the sample", name);
            return;
        end
        if (inReady) highCount++;
        checkValue({name, " inReady while busy"}, 0, highCount);
        checkValue({name, " outL"}, expL, outL);
        checkValue({name, " outR"}, expR, outR);
    endtask

    task automatic testReset();
        int errBefore;
        errBefore = errorCount;
        @(negedge clk);
        checkValue("reset inReady", 1, inReady);
        checkValue("reset outReady", 0, outReady);
        checkValue("reset outL", 0, outL);
        checkValue("reset outR", 0, outR);
        finishTest("reset", errBefore);
    endtask

    task automatic testImpulse();
        int errBefore;
        errBefore = errorCount;
        loadTables(16'h0a41, 8'h07); // group 0 empty, taps 0..7 only
        runSample("impulse 0", 16'sh4000, 16'shc000, 1'b0);
        for (int i = 1; i < 8; i++) begin
            runSample($sformatf("impulse %0d", i), '0, '0, 1'b0);
        end
        finishTest("impulse", errBefore);
    endtask

    task automatic testRandom();
        int errBefore;
        errBefore = errorCount;
        applyReset();
        loadTables(16'h8012, 8'hff); // last group empty
        runSample("random 0", 16'sh8000, 16'sh7fff, 1'b0);
        for (int i = 1; i < 12; i++) begin
            runSample($sformatf("random %0d", i), sampleT'($random(seed)),
                      sampleT'($random(seed)), 1'b0);
        end
        finishTest("random", errBefore);
    endtask

    task automatic testBusyFrame();
        int errBefore;
        errBefore = errorCount;
        runSample("busy frame", sampleT'($random(seed)), sampleT'($random(seed)), 1'b1);
        runSample("after busy frame", sampleT'($random(seed)), sampleT'($random(seed)), 1'b0);
        finishTest("busy frame", errBefore);
    endtask

    task automatic testMidRunReset();
        int errBefore;
        errBefore = errorCount;
        sendWord(16'h1234, 16'hedcb);
        repeat (100) @(negedge clk); // well inside the walk
        checkValue("mid-run inReady", 0, inReady);
        applyReset();
        @(negedge clk);
        checkValue("reload inReady", 1, inReady);
        checkValue("reload outReady", 0, outReady);
        checkValue("reload outL", 0, outL);
        checkValue("reload outR", 0, outR);
        loadTables(16'h0300, 8'h0f);
        for (int i = 0; i < 4; i++) begin
            runSample($sformatf("reload %0d", i), sampleT'($random(seed)),
                      sampleT'($random(seed)), 1'b0);
        end
        finishTest("mid-run reset", errBefore);
    endtask

    initial begin
        seed = 32'h1011_fbc0;
        rst = 1'b1;
        frame = 1'b0;
        inL = 1'b0;
        inR = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        testReset();
        testImpulse();
        testRandom();
        testBusyFrame();
        testMidRunReset();
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
logic/msdapPkg.sv
logic/loadBus.sv
logic/tapPort.sv
logic/serialIn.sv
logic/loadControl.sv
logic/tapStore.sv
logic/macEngine.sv
logic/msdapTop.sv
bench/tbMsdap.sv

// File: Bender.yml
package:
  name: msdap

sources:
  - logic/msdapPkg.sv
  - logic/loadBus.sv
  - logic/tapPort.sv
  - logic/serialIn.sv
  - logic/loadControl.sv
  - logic/tapStore.sv
  - logic/macEngine.sv
  - logic/msdapTop.sv
  - target: simulation
    files:
      - bench/tbMsdap.sv
